/* project.f */
+incdir+rtl
rtl/tcdm_bus_pkg.sv
rtl/tcdm_arb_pkg.sv
rtl/tcdm_mux_ooo.sv
rtl/tcdm_user_filter.sv
rtl/tcdm_sram_bank.sv
rtl/tcdm_subsystem_top.sv
sim/tb_tcdm_subsystem.sv

/* Bender.yml */
package:
  name: tcdm_subsystem

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/tcdm_bus_pkg.sv
      - rtl/tcdm_arb_pkg.sv
      - rtl/tcdm_mux_ooo.sv
      - rtl/tcdm_user_filter.sv
      - rtl/tcdm_sram_bank.sv
      - rtl/tcdm_subsystem_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - sim/tb_tcdm_subsystem.sv

/* sim/tb_tcdm_subsystem.sv */
// tcdm subsystem testbench with clock, reset, initiator drivers, scoreboard, assertions and timeout
`include "tcdm_defines.svh"

module tb_tcdm_subsystem;
  timeunit 1ns;
  timeprecision 100ps;

  import tcdm_bus_pkg::*;
  import tcdm_arb_pkg::*;

  localparam int NB       = `TCDM_NB_CHAN;
  localparam int CLK_HALF = 4;                 // 8 ns period
  localparam int RST_CYC  = 8;
  localparam int WIN      = 4 * NB;            // words preset by write_read where later traffic stays
  localparam int MAX_CYC  = 2000;              // about ten times the whole test traffic

  typedef logic [NB-1:0] chan_mask_t;

  logic           clk_i;
  logic           rst_ni;
  logic           clear_i;
  logic           priority_force_i;
  prio_vec_t      priority_i;
  chan_mask_t     in_req, in_wen, in_gnt, in_r_valid;
  addr_t [NB-1:0] in_add;
  data_t [NB-1:0] in_data;
  be_t   [NB-1:0] in_be;
  data_t          in_r_data;

  // reference model state
  data_t      shadow [2**`TCDM_AW];            // expected bank contents
  chan_idx_t  ptr_m;                           // expected round-robin pointer
  logic       rdy_m;                           // memory port grants one edge after reset release
  chan_mask_t exp_gnt;                         // grant the rules call for this cycle
  chan_mask_t exp_pend;                        // response owed this cycle
  chan_mask_t exp_rd;                          // owed response is a read
  data_t      exp_data [NB];

  string test_name;
  int    err_cnt, fail_cnt, test_cnt, test_fails;
  int    rd_checked;
  int    cyc = 0;
  int    seed = 32'h67f0;

  tcdm_subsystem_top i_tcdm_subsystem_top (.*);

  initial begin : clk_gen
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  // arbitration rule walks the ranks and the first requester wins
  function automatic chan_mask_t pick_grant(input chan_mask_t req, input chan_idx_t ptr,
                                            input logic force_mode, input prio_vec_t prio);
    chan_mask_t g;
    int         ch;
    g = '0;
    for (int r = 0; r < NB; r++) begin
      ch = force_mode ? int'(prio[r]) : (int'(ptr) + r) % NB;   // channel holding rank r
      if (g == '0 && req[ch]) begin
        g[ch] = 1'b1;
      end
    end
    return g;
  endfunction

  assign exp_gnt = rdy_m ? pick_grant(in_req, ptr_m, priority_force_i, priority_i) : '0;

  always @(posedge clk_i or negedge rst_ni) begin : scoreboard
    if (!rst_ni) begin
      ptr_m    <= '0;
      rdy_m    <= 1'b0;
      exp_pend <= '0;
    end else begin
      rdy_m    <= 1'b1;
      exp_pend <= exp_gnt;                     // response due one edge after acceptance
      if (clear_i) begin
        ptr_m <= '0;
      end else if (exp_gnt != '0) begin
        ptr_m <= chan_idx_t'((int'(ptr_m) + 1) % NB);
      end
      for (int c = 0; c < NB; c++) begin
        if (exp_pend[c] && exp_rd[c]) rd_checked++;
        if (exp_gnt[c]) begin
          exp_rd[c]   <= in_wen[c];
          exp_data[c] <= shadow[in_add[c]];    // bank holds the pre-write word at this point
          if (!in_wen[c]) begin
            for (int b = 0; b < `TCDM_DW / `TCDM_BW; b++) begin
              if (in_be[c][b]) shadow[in_add[c]][b*`TCDM_BW +: `TCDM_BW] <=
                  in_data[c][b*`TCDM_BW +: `TCDM_BW];
            end
          end
        end
      end
    end
  end

  task automatic note_fail(input string what, input logic [63:0] exp, input logic [63:0] act);
    $display("FAIL %s %s: expected %0h actual %0h", test_name, what, exp, act);
    err_cnt++;
    fail_cnt++;
  endtask

  gnt_chk: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    in_gnt == exp_gnt
  ) else note_fail("grant", $sampled(exp_gnt), $sampled(in_gnt));

  // only the owner of the accepted request sees r_valid
  route_chk: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    in_r_valid == exp_pend
  ) else note_fail("r_valid", $sampled(exp_pend), $sampled(in_r_valid));

  rst_chk: assert property (
    @(posedge clk_i)
    (!rst_ni || $rose(rst_ni)) |-> (in_gnt == '0 && in_r_valid == '0)
  ) else note_fail("gnt and r_valid near reset", '0, {$sampled(in_gnt), $sampled(in_r_valid)});

  // first grant after a clear goes to channel 0
  clear_chk: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ($fell(clear_i) && !priority_force_i && in_req[0]) |-> in_gnt[0]
  ) else note_fail("grant after clear", 1, $sampled(in_gnt));

  for (genvar g = 0; g < NB; g++) begin : gen_rd_chk
    rd_data_chk: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      (exp_pend[g] && exp_rd[g]) |-> in_r_data == exp_data[g]
    ) else note_fail("read data", $sampled(exp_data[g]), $sampled(in_r_data));
  end

  // one request on one channel with fields held until the grant is seen
  task automatic drive_req(input int c, input logic rd, input addr_t a, input data_t d,
                           input be_t b);
    in_wen[c]  = rd;
    in_add[c]  = a;
    in_data[c] = d;
    in_be[c]   = b;
    in_req[c]  = 1'b1;
    do begin
      @(negedge clk_i);                        // gnt settled mid-cycle
    end while (!in_gnt[c]);
    @(posedge clk_i);
    #1 in_req[c] = 1'b0;                       // next call may raise it again right away
  endtask

  task automatic chan_wr_rd(input int c);
    addr_t a;
    for (int k = 0; k < 4; k++) begin
      drive_req(c, 1'b0, addr_t'(c * 4 + k), data_t'($random(seed)), '1);  // full word first
    end
    for (int k = 0; k < 4; k++) begin
      a = addr_t'(c * 4 + k);
      drive_req(c, 1'b0, a, data_t'($random(seed)), be_t'($random(seed)));
      drive_req(c, 1'b1, a, '0, '0);           // read pipelined behind the partial write
    end
  endtask

  task automatic chan_traffic(input int c, input int n, input bit rd_ok);
    logic  rd;
    addr_t a;
    for (int i = 0; i < n; i++) begin
      rd = rd_ok && (($random(seed) & 1) != 0);
      a  = addr_t'($unsigned($random(seed)) % WIN);
      drive_req(c, rd, a, data_t'($random(seed)), be_t'($random(seed)));
    end
  endtask

  // masked channels run side by side until all are done
  task automatic run_group(input chan_mask_t mask, input int n, input bit rd_ok,
                           input bit wr_rd);
    for (int c = 0; c < NB; c++) begin
      if (mask[c]) begin
        fork
          automatic int cc = c;
          if (wr_rd) chan_wr_rd(cc);
          else chan_traffic(cc, n, rd_ok);
        join_none
      end
    end
    wait fork;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_cnt   = 0;
  endtask

  task automatic end_test();
    repeat (2) @(posedge clk_i);               // let the last response get checked
    #1;
    test_cnt++;
    if (err_cnt == 0) begin
      $display("%-12s ok", test_name);
    end else begin
      test_fails++;
      $display("%-12s %0d errors", test_name, err_cnt);
    end
  endtask

  initial begin : main
    rst_ni           = 1'b0;
    clear_i          = 1'b0;
    priority_force_i = 1'b0;
    priority_i       = '0;
    in_req           = '0;
    in_wen           = '0;
    in_add           = '0;
    in_data          = '0;
    in_be            = '0;
    fail_cnt         = 0;
    test_cnt         = 0;
    test_fails       = 0;
    rd_checked       = 0;

    start_test("reset");
    repeat (RST_CYC) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    end_test();

    start_test("write_read");
    run_group('1, 0, 1'b0, 1'b1);
    end_test();

    start_test("routing");
    run_group('1, 8, 1'b1, 1'b0);
    end_test();

    // everyone asks straight out of a fresh reset so the order starts at channel 0
    start_test("rr_reset");
    rst_ni = 1'b0;
    fork
      begin
        repeat (RST_CYC) @(posedge clk_i);
        #1 rst_ni = 1'b1;
      end
    join_none
    run_group('1, 6, 1'b0, 1'b0);
    end_test();

    start_test("rr_subset");
    run_group(chan_mask_t'(4'b1010), 6, 1'b1, 1'b0);
    run_group(chan_mask_t'(4'b0111), 4, 1'b1, 1'b0);
    end_test();

    start_test("forced_prio");
    priority_force_i = 1'b1;
    for (int r = 0; r < NB; r++) begin
      priority_i[r] = chan_idx_t'((2 + 3 * r) % NB);   // a shuffled order
    end
    run_group('1, 2, 1'b0, 1'b0);
    for (int r = 0; r < NB; r++) begin
      priority_i[r] = chan_idx_t'(NB - 1 - r);         // highest channel first
    end
    run_group(chan_mask_t'(4'b0110), 3, 1'b1, 1'b0);
    priority_force_i = 1'b0;
    end_test();

    start_test("clear");
    fork
      begin
        repeat (11) @(posedge clk_i);          // pointer is away from 0 by then
        #1 clear_i = 1'b1;
        @(posedge clk_i);
        #1 clear_i = 1'b0;
      end
    join_none
    run_group('1, 6, 1'b0, 1'b0);
    end_test();

    if (rd_checked == 0) begin
      $display("no read response reached the data check");
      fail_cnt++;
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors, %0d reads checked",
             test_cnt, test_cnt - test_fails, test_fails, fail_cnt, rd_checked);
    if (test_fails == 0 && fail_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  always @(posedge clk_i) begin : watchdog
    cyc++;
    if (cyc >= MAX_CYC) begin
      $display("timeout after %0d cycles, test %s never finished", cyc, test_name);
      $display("TEST FAIL");
      $finish;
    end
  end

endmodule

/* rtl/tcdm_subsystem_top.sv */
// tcdm subsystem top: ooo mux, user filter and sram bank behind nb_chan initiator ports
`include "tcdm_defines.svh"

module tcdm_subsystem_top (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    clear_i,
  input  logic                                    priority_force_i,
  input  tcdm_arb_pkg::prio_vec_t                 priority_i,

  // initiator ports, one lane per channel
  input  logic [`TCDM_NB_CHAN-1:0]                in_req,
  input  logic [`TCDM_NB_CHAN-1:0]                in_wen,
  input  tcdm_bus_pkg::addr_t [`TCDM_NB_CHAN-1:0] in_add,
  input  tcdm_bus_pkg::data_t [`TCDM_NB_CHAN-1:0] in_data,
  input  tcdm_bus_pkg::be_t   [`TCDM_NB_CHAN-1:0] in_be,
  output logic [`TCDM_NB_CHAN-1:0]                in_gnt,
  output logic [`TCDM_NB_CHAN-1:0]                in_r_valid,
  output tcdm_bus_pkg::data_t                     in_r_data
);

  import tcdm_bus_pkg::*;

  // mux <-> filter
  logic  out_req, out_wen, out_gnt;
  addr_t out_add;
  data_t out_data;
  be_t   out_be;
  id_t   out_id;
  logic  out_r_valid;
  data_t out_r_data;
  id_t   out_r_id;

  // filter <-> bank
  logic  mem_en, mem_wen;
  addr_t mem_add;
  data_t mem_data, mem_rdata;
  be_t   mem_be;

  tcdm_mux_ooo i_mux (
    .clk_i, .rst_ni, .clear_i, .priority_force_i, .priority_i,
    .in_req, .in_wen, .in_add, .in_data, .in_be,
    .in_gnt, .in_r_valid, .in_r_data,
    .out_req, .out_wen, .out_add, .out_data, .out_be, .out_id,
    .out_gnt, .out_r_valid, .out_r_data, .out_r_id
  );

  tcdm_user_filter i_filter (
    .clk_i, .rst_ni,
    .req     (out_req),
    .wen     (out_wen),
    .add     (out_add),
    .data    (out_data),
    .be      (out_be),
    .id      (out_id),
    .gnt     (out_gnt),
    .r_valid (out_r_valid),
    .r_data  (out_r_data),
    .r_id    (out_r_id),
    .mem_en, .mem_wen, .mem_add, .mem_data, .mem_be, .mem_rdata
  );

  tcdm_sram_bank i_bank (
    .clk_i, .rst_ni,
    .en    (mem_en),
    .wen   (mem_wen),
    .add   (mem_add),
    .wdata (mem_data),
    .be    (mem_be),
    .rdata (mem_rdata)
  );

endmodule

/* rtl/tcdm_sram_bank.sv */
// single-port byte-enabled sram bank with one-cycle registered read
`include "tcdm_defines.svh"

module tcdm_sram_bank (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                en,        // access strobe
  input  logic                wen,       // 1 = read, 0 = write
  input  tcdm_bus_pkg::addr_t add,
  input  tcdm_bus_pkg::data_t wdata,
  input  tcdm_bus_pkg::be_t   be,
  output tcdm_bus_pkg::data_t rdata
);

  import tcdm_bus_pkg::*;

  localparam int unsigned DEPTH = 2 ** `TCDM_AW;   // every address maps to a word
  localparam int unsigned LANES = `TCDM_DW / `TCDM_BW;

  data_t mem_q [DEPTH];

  // byte-wise write, untouched lanes keep their old value
  always_ff @(posedge clk_i) begin : mem_write
    if (en && !wen) begin
      for (int b = 0; b < LANES; b++) begin
        if (be[b]) begin
          mem_q[add][b*`TCDM_BW +: `TCDM_BW] <= wdata[b*`TCDM_BW +: `TCDM_BW];
        end
      end
    end
  end

  // read port, data shows up the cycle after the access
  always_ff @(posedge clk_i or negedge rst_ni) begin : mem_read
    if (!rst_ni) begin
      rdata <= '0;
    end else if (en && wen) begin
      rdata <= mem_q[add];                         // holds between reads
    end
  end

endmodule

/* rtl/tcdm_user_filter.sv */
// user filter at the memory boundary, grants requests and reflects the id with the response
`include "tcdm_defines.svh"

module tcdm_user_filter (
  input  logic                clk_i,
  input  logic                rst_ni,

  // request from the mux
  input  logic                req,
  input  logic                wen,          // 1 = read
  input  tcdm_bus_pkg::addr_t add,
  input  tcdm_bus_pkg::data_t data,
  input  tcdm_bus_pkg::be_t   be,
  input  tcdm_bus_pkg::id_t   id,
  output logic                gnt,

  // response back to the mux
  output logic                r_valid,
  output tcdm_bus_pkg::data_t r_data,
  output tcdm_bus_pkg::id_t   r_id,

  // bank port
  output logic                mem_en,
  output logic                mem_wen,
  output tcdm_bus_pkg::addr_t mem_add,
  output tcdm_bus_pkg::data_t mem_data,
  output tcdm_bus_pkg::be_t   mem_be,
  input  tcdm_bus_pkg::data_t mem_rdata
);

  import tcdm_bus_pkg::*;

  logic ready_q;                            // goes high one edge after reset release
  logic accept;
  id_t  id_q;                               // id of the request now in the bank

  assign gnt    = ready_q;                  // the bank never stalls
  assign accept = req & ready_q;

  // bank sees the request only when it is accepted
  assign mem_en   = accept;
  assign mem_wen  = wen;
  assign mem_add  = add;
  assign mem_data = data;
  assign mem_be   = be;

  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
    if (!rst_ni) begin
      ready_q <= 1'b0;
      r_valid <= 1'b0;
    end else begin
      ready_q <= 1'b1;
      r_valid <= accept;                    // one pulse per request, reads and writes
    end
  end

  // id travels alongside the bank access, same latency as the read data
  always_ff @(posedge clk_i) begin : id_reg
    if (accept) id_q <= id;
  end

  assign r_id   = id_q;
  assign r_data = mem_rdata;                // bank output is already registered

  // response is the echo of a handshake one cycle before
  rsp_after_acc: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    r_valid |-> $past(req && gnt)
  ) else $error("tcdm_user_filter: response without a prior handshake");

endmodule

/* rtl/tcdm_mux_ooo.sv */
// out-of-order n-to-1 tcdm multiplexer with round-robin or forced arbitration and id-steered responses
`include "tcdm_defines.svh"

module tcdm_mux_ooo (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           clear_i,          // sync pointer reset

  input  logic                                           priority_force_i, // use priority_i
  input  tcdm_arb_pkg::prio_vec_t                        priority_i,

  // initiator side with one lane per channel
  input  logic [`TCDM_NB_CHAN-1:0]                       in_req,
  input  logic [`TCDM_NB_CHAN-1:0]                       in_wen,           // 1 = read
  input  tcdm_bus_pkg::addr_t [`TCDM_NB_CHAN-1:0]        in_add,
  input  tcdm_bus_pkg::data_t [`TCDM_NB_CHAN-1:0]        in_data,
  input  tcdm_bus_pkg::be_t   [`TCDM_NB_CHAN-1:0]        in_be,
  output logic [`TCDM_NB_CHAN-1:0]                       in_gnt,
  output logic [`TCDM_NB_CHAN-1:0]                       in_r_valid,
  output tcdm_bus_pkg::data_t                            in_r_data,        // broadcast

  // single port toward the memory side
  output logic                                           out_req,
  output logic                                           out_wen,
  output tcdm_bus_pkg::addr_t                            out_add,
  output tcdm_bus_pkg::data_t                            out_data,
  output tcdm_bus_pkg::be_t                              out_be,
  output tcdm_bus_pkg::id_t                              out_id,
  input  logic                                           out_gnt,
  input  logic                                           out_r_valid,
  input  tcdm_bus_pkg::data_t                            out_r_data,
  input  tcdm_bus_pkg::id_t                              out_r_id
);

  import tcdm_bus_pkg::*;
  import tcdm_arb_pkg::*;

  chan_idx_t ptr_q;                              // round-robin pointer
  prio_vec_t rank_list;                          // rank to channel map where rank 0 wins
  chan_idx_t winner;                             // channel picked this cycle
  logic      accept;                             // handshake on the output port

  assign accept = out_req & out_gnt;

  // pointer moves by one per accepted request in either mode
  always_ff @(posedge clk_i or negedge rst_ni) begin : rr_ptr
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (clear_i) begin
      ptr_q <= '0;                               // clear wins over an accept
    end else if (accept) begin
      ptr_q <= rr_next(ptr_q);
    end
  end

  for (genvar ii = 0; ii < `TCDM_NB_CHAN; ii++) begin : gen_chan
    // rotated list starts at the pointer while the forced list comes straight in
    assign rank_list[ii] = priority_force_i ? priority_i[ii] : rr_slot(ptr_q, ii);

    // only the scan winner sees a grant, and only while someone is asking
    assign in_gnt[ii] = (winner == chan_idx_t'(ii)) & (|in_req) & out_gnt;

    // response goes back to whoever owns the reflected id
    assign in_r_valid[ii] = (out_r_id == id_t'(ii)) & out_r_valid;
  end

  // winner-takes-all scan from the last rank down so rank 0 has the last word
  always_comb begin : wta_scan
    winner = ptr_q;                              // default when nobody asks
    for (int jj = `TCDM_NB_CHAN - 1; jj >= 0; jj--) begin
      if (in_req[rank_list[jj]]) begin
        winner = rank_list[jj];
      end
    end
  end

  // forward the winner's fields tagged with its channel number
  assign out_req  = in_req[winner];
  assign out_wen  = in_wen[winner];
  assign out_add  = in_add[winner];
  assign out_data = in_data[winner];
  assign out_be   = in_be[winner];
  assign out_id   = id_t'(winner);

  assign in_r_data = out_r_data;                 // data is shared and r_valid picks the owner

  // at most one channel granted per cycle
  gnt_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0(in_gnt)
  ) else $error("tcdm_mux_ooo: several channels granted at once");

  // a grant never lands on an idle channel
  gnt_has_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (in_gnt & ~in_req) == '0
  ) else $error("tcdm_mux_ooo: grant without request");

endmodule

/* rtl/tcdm_arb_pkg.sv */
// arbitration types and pointer helpers: channel index and priority vector
`include "tcdm_defines.svh"

package tcdm_arb_pkg;

  localparam int unsigned CHAN_IDX_W = $clog2(`TCDM_NB_CHAN);

  typedef logic [CHAN_IDX_W-1:0] chan_idx_t;                     // one channel number
  typedef chan_idx_t [`TCDM_NB_CHAN-1:0] prio_vec_t;             // entry 0 is highest

  // pointer step, wraps at the channel count even when it is not a power of two
  function automatic chan_idx_t rr_next(chan_idx_t ptr);
    if (ptr == chan_idx_t'(`TCDM_NB_CHAN - 1)) return '0;
    return ptr + 1'b1;
  endfunction

  // channel sitting at a given rank when the rotation starts at ptr
  function automatic chan_idx_t rr_slot(chan_idx_t ptr, int unsigned rank);
    return chan_idx_t'((int'(ptr) + rank) % `TCDM_NB_CHAN);
  endfunction

endpackage

/* rtl/tcdm_bus_pkg.sv */
// bus word types of the tcdm subsystem: address, data, byte enable and response id
`include "tcdm_defines.svh"

package tcdm_bus_pkg;

  // id carries the channel number, so it needs log2 of the channel count
  localparam int unsigned ID_W = $clog2(`TCDM_NB_CHAN);

  // one byte enable bit per byte lane
  localparam int unsigned BE_W = `TCDM_DW / `TCDM_BW;

  typedef logic [`TCDM_AW-1:0] addr_t; // word address
  typedef logic [`TCDM_DW-1:0] data_t; // one data word
  typedef logic [BE_W-1:0]     be_t;   // byte enables
  typedef logic [ID_W-1:0]     id_t;   // user field used as response id

endpackage

/* rtl/tcdm_defines.svh */
// macros for channel count and bus widths of the tcdm subsystem
`ifndef TCDM_DEFINES_SVH
`define TCDM_DEFINES_SVH

// number of initiator channels funneled into the bank
`define TCDM_NB_CHAN 4

// word address width, 256 words deep
`define TCDM_AW 8

// data word width
`define TCDM_DW 32

// bits covered by one byte enable lane
`define TCDM_BW 8

`endif
